/* common/spi_pkg.sv */
//######################################
// Shared constants and types for the SPI
// master transmit path. Imported by the
// modules and the interface that need it
//######################################
`default_nettype none

package spi_pkg;

   //######################################
   // Widths
   //######################################
   localparam int PW = 104;        // Core packet width
   localparam int AW = 32;         // Address and data width
   localparam int SW = 8;          // Byte width on FIFO and wire
   localparam int DW = 2 * AW;     // Transmit payload, srcaddr over data
   localparam int OW = 6;          // Register offset width

   // Packet field positions
   localparam int WRITE_BIT = 0;
   localparam int DM_LSB    = 1;   // 2 bits
   localparam int DST_LSB   = 8;   // Ctrlmode sits in 7:3, unused here
   localparam int DATA_LSB  = 40;
   localparam int SRC_LSB   = 72;

   //######################################
   // Register map
   //######################################
   localparam logic [OW-1:0] SPI_CONFIG = 6'h00; // Bit 0 enable
   localparam logic [OW-1:0] SPI_CLKDIV = 6'h04; // Half-period minus one
   localparam logic [OW-1:0] SPI_TX     = 6'h10; // Transmit payload

   // Access size, 1/2/4/8 bytes
   typedef enum logic [1:0] {
      DM_BYTE   = 2'd0,
      DM_HALF   = 2'd1,
      DM_WORD   = 2'd2,
      DM_DOUBLE = 2'd3
   } datamode_e;

   // Shift engine states
   typedef enum logic [1:0] {
      IO_IDLE  = 2'd0,   // ss_n high, waiting for data
      IO_LOAD  = 2'd1,   // First pop of a burst
      IO_SHIFT = 2'd2,   // Bits on the wire
      IO_GAP   = 2'd3    // Half-period before ss_n rises
   } io_state_e;

endpackage

`default_nettype wire

/* common/emesh_if.sv */
//######################################
// One decoded core access. The decoder
// drives it, the transmit FIFO returns
// wait, the register block only listens
//######################################
`timescale 1ns/1ps
`default_nettype none

interface emesh_if import spi_pkg::*; ();

   logic            access;     // Held by core until taken
   logic            write;
   datamode_e       datamode;
   logic [AW-1:0]   dstaddr;
   logic [AW-1:0]   srcaddr;
   logic [AW-1:0]   data;
   logic            wait_req;   // Stall back to core

   modport decoder  (output access, write, datamode, dstaddr, srcaddr, data,
                     input  wait_req);
   modport consumer (input  access, write, datamode, dstaddr, srcaddr, data,
                     output wait_req);
   modport monitor  (input  access, write, dstaddr, data, wait_req);

endinterface

`default_nettype wire

/* logic/emesh_decode.sv */
//######################################
// Packet field decoder. Purely
// combinational, splits the core packet
// onto the access interface
//######################################
`timescale 1ns/1ps
`default_nettype none

module emesh_decode import spi_pkg::*; (
   input  logic          access_in,   // Core strobe
   input  logic [PW-1:0] packet_in,   // Core packet
   output logic          wait_out,    // Pushback to core
   emesh_if.decoder      acc
);

   // Strobe passes straight through
   assign acc.access   = access_in;

   //######################################
   // Field slicing
   //######################################
   assign acc.write    = packet_in[WRITE_BIT];
   assign acc.datamode = datamode_e'(packet_in[DM_LSB +: 2]);
   assign acc.dstaddr  = packet_in[DST_LSB +: AW];
   assign acc.data     = packet_in[DATA_LSB +: AW];
   assign acc.srcaddr  = packet_in[SRC_LSB +: AW];   // Upper payload word

   // Consumer stall goes back to the core
   assign wait_out     = acc.wait_req;

endmodule

`default_nettype wire

/* logic/par2ser.sv */
//######################################
// Wide word to byte serializer. Load a
// word, then one byte per cycle goes out
// LSB first, holding while wait_in is up
//######################################
`timescale 1ns/1ps
`default_nettype none

module par2ser import spi_pkg::*; (
   input  logic          clk,
   input  logic          arst_n,
   input  logic [DW-1:0] din,         // Word to serialize
   input  datamode_e     datasize,    // Number of bytes in din
   input  logic          load,        // Capture din
   input  logic          wait_in,     // Downstream back-pressure
   output logic [SW-1:0] dout,        // Current byte
   output logic          access_out,  // Byte valid this cycle
   output logic          busy         // Bytes still pending
);

   logic [DW-1:0] shreg;      // Remaining bytes, next at bottom
   logic [3:0]    cnt;        // Bytes left, up to 8
   logic [3:0]    load_cnt;
   logic          advance;

   // Byte count for the access size
   always_comb begin
      case (datasize)
         DM_BYTE:   load_cnt = 4'd1;
         DM_HALF:   load_cnt = 4'd2;
         DM_WORD:   load_cnt = 4'd4;
         default:   load_cnt = 4'd8;   // DM_DOUBLE
      endcase
   end

   assign advance    = busy && !wait_in;   // Byte leaves this edge
   assign access_out = advance;
   assign dout       = shreg[SW-1:0];

   //######################################
   // Control
   //######################################
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy <= 1'b0;
         cnt  <= 4'd0;
      end else if (load && !busy) begin
         busy <= 1'b1;
         cnt  <= load_cnt;
      end else if (advance) begin
         cnt <= cnt - 4'd1;
         if (cnt == 4'd1)
            busy <= 1'b0;   // Last byte written this edge
      end
   end

   // Payload shifter
   always_ff @(posedge clk) begin
      if (load && !busy)
         shreg <= din;
      else if (advance)
         shreg <= {{SW{1'b0}}, shreg[DW-1:SW]};
   end

   // Caller must respect busy, else a word is dropped
   a_no_load_busy: assert property (@(posedge clk) disable iff (!arst_n)
      load |-> !busy);

endmodule

`default_nettype wire

/* logic/fifo_sync.sv */
//######################################
// Single clock FIFO, show-ahead output.
// dout is the head entry, rd_en pops it
// prog_full rises PROG_GAP below full
//######################################
`timescale 1ns/1ps
`default_nettype none

module fifo_sync import spi_pkg::*; #(
   parameter int DEPTH    = 16,   // Entries
   parameter int PROG_GAP = 4     // Headroom below full
) (
   input  logic          clk,
   input  logic          arst_n,
   input  logic [SW-1:0] din,
   input  logic          wr_en,
   input  logic          rd_en,
   output logic [SW-1:0] dout,
   output logic          full,
   output logic          prog_full,
   output logic          empty
);

   localparam int PTRW = $clog2(DEPTH);
   localparam int CW   = $clog2(DEPTH + 1);

   logic [SW-1:0]   mem [DEPTH];
   logic [PTRW-1:0] wr_ptr;
   logic [PTRW-1:0] rd_ptr;
   logic [CW-1:0]   count;
   logic            do_wr;
   logic            do_rd;

   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   // Flags from the registered count
   assign empty     = (count == '0);
   assign full      = (count == CW'(DEPTH));
   assign prog_full = (count >= CW'(DEPTH - PROG_GAP));
   assign dout      = mem[rd_ptr];     // Head visible before pop

   //######################################
   // Pointers and occupancy
   //######################################
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr)
            wr_ptr <= (wr_ptr == PTRW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= (rd_ptr == PTRW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (do_wr && !do_rd)
            count <= count + 1'b1;
         else if (do_rd && !do_wr)
            count <= count - 1'b1;
      end
   end

   // Storage
   always_ff @(posedge clk) begin
      if (do_wr)
         mem[wr_ptr] <= din;
   end

   a_no_write_full: assert property (@(posedge clk) disable iff (!arst_n)
      wr_en |-> !full);
   a_no_read_empty: assert property (@(posedge clk) disable iff (!arst_n)
      rd_en |-> !empty);

endmodule

`default_nettype wire

/* spi_master/spi_master_fifo.sv */
//######################################
// Transmit FIFO block. Picks out writes
// to the TX offset, serializes payload
// bytes into the byte FIFO for the wire
//######################################
`timescale 1ns/1ps
`default_nettype none

module spi_master_fifo import spi_pkg::*; #(
   parameter int DEPTH    = 16,   // FIFO entries
   parameter int PROG_GAP = 4     // prog_full headroom
) (
   input  logic          clk,
   input  logic          arst_n,
   input  logic          spi_en,          // Global enable
   emesh_if.consumer     acc,             // Decoded core access
   input  logic          fifo_read,       // Pop from shift engine
   output logic          fifo_empty,
   output logic [SW-1:0] fifo_dout,       // Head byte
   output logic          fifo_prog_full   // Status that also stalls par2ser
);

   logic          tx_write;
   logic          tx_busy;
   logic [DW-1:0] tx_data;
   logic [SW-1:0] fifo_din;
   logic          fifo_wr;

   // Accepted TX write only while serializer idle
   assign tx_write = spi_en && acc.access && acc.write && !tx_busy &&
                     (acc.dstaddr[OW-1:0] == SPI_TX);

   assign tx_data      = {acc.srcaddr, acc.data};   // LSB first gives data first
   assign acc.wait_req = tx_busy;                   // Core stalls while serializing

   //######################################
   // Serializer and storage
   //######################################
   par2ser ser0 (
      .clk        (clk),
      .arst_n     (arst_n),
      .din        (tx_data),
      .datasize   (acc.datamode),
      .load       (tx_write),
      .wait_in    (fifo_prog_full),
      .dout       (fifo_din),
      .access_out (fifo_wr),
      .busy       (tx_busy)
   );

   fifo_sync #(
      .DEPTH    (DEPTH),
      .PROG_GAP (PROG_GAP)
   ) fifo0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .din       (fifo_din),
      .wr_en     (fifo_wr),
      .rd_en     (fifo_read),
      .dout      (fifo_dout),
      .full      (),            // Never reached behind prog_full
      .prog_full (fifo_prog_full),
      .empty     (fifo_empty)
   );

endmodule

`default_nettype wire

/* spi_master/spi_master_regs.sv */
//######################################
// Control registers: enable and sclk
// divider. Written by core accesses,
// read-back is not supported
//######################################
`timescale 1ns/1ps
`default_nettype none

module spi_master_regs import spi_pkg::*; (
   input  logic        clk,
   input  logic        arst_n,
   emesh_if.monitor    acc,      // Observes every decoded access
   output logic        spi_en,   // Engine and TX path enable
   output logic [7:0]  clkdiv    // Half-period is clkdiv+1 cycles
);

   logic reg_write;

   // Same acceptance rule as the core handshake
   assign reg_write = acc.access && acc.write && !acc.wait_req;

   //######################################
   // Register file
   //######################################
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         spi_en <= 1'b0;
         clkdiv <= 8'd0;   // Fastest sclk until written
      end else if (reg_write) begin
         case (acc.dstaddr[OW-1:0])
            SPI_CONFIG: spi_en <= acc.data[0];
            SPI_CLKDIV: clkdiv <= acc.data[7:0];
            default: begin
               // TX and unmapped offsets leave registers alone
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* spi_master/spi_master_io.sv */
//######################################
// SPI mode 0 shift engine. Pops bytes
// from the transmit FIFO, sends them MSB
// first on mosi, frames bursts with ss_n
//######################################
`timescale 1ns/1ps
`default_nettype none

module spi_master_io import spi_pkg::*; (
   input  logic          clk,
   input  logic          arst_n,
   input  logic          spi_en,
   input  logic [7:0]    clkdiv,       // Half-period minus one
   input  logic          fifo_empty,
   input  logic [SW-1:0] fifo_dout,    // Head byte, show-ahead
   output logic          fifo_read,    // Pop head this edge
   output logic          sclk,
   output logic          mosi,
   output logic          ss_n
);

   io_state_e     state;
   logic [7:0]    half_cnt;    // Cycles into current half-period
   logic [2:0]    bit_cnt;     // Bit on wire, 7 down to 0
   logic [SW-1:0] shreg;       // Bits still to send, next at top
   logic          half_done;
   logic          fall;        // sclk falls this edge
   logic          byte_end;
   logic          more;

   assign half_done = (half_cnt >= clkdiv);   // Tolerates divider change mid-bit
   assign fall      = (state == IO_SHIFT) && half_done && sclk;
   assign byte_end  = fall && (bit_cnt == 3'd0);
   assign more      = spi_en && !fifo_empty;
   // First pop in LOAD, back-to-back pops at byte end
   assign fifo_read = (state == IO_LOAD) || (byte_end && more);

   //######################################
   // Framing FSM
   //######################################
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= IO_IDLE;
         half_cnt <= 8'd0;
         bit_cnt  <= 3'd0;
         sclk     <= 1'b0;
         mosi     <= 1'b0;
         ss_n     <= 1'b1;
      end else begin
         case (state)
            IO_IDLE: begin
               half_cnt <= 8'd0;
               if (more) begin
                  ss_n  <= 1'b0;   // Select ahead of first bit
                  state <= IO_LOAD;
               end
            end
            IO_LOAD: begin
               mosi     <= fifo_dout[SW-1];   // MSB before first rise
               bit_cnt  <= 3'd7;
               half_cnt <= 8'd0;
               state    <= IO_SHIFT;
            end
            IO_SHIFT: begin
               if (!half_done) begin
                  half_cnt <= half_cnt + 8'd1;
               end else begin
                  half_cnt <= 8'd0;
                  sclk     <= ~sclk;
                  if (sclk) begin   // Falling edge, mosi may change
                     if (bit_cnt != 3'd0) begin
                        mosi    <= shreg[SW-1];
                        bit_cnt <= bit_cnt - 3'd1;
                     end else if (more) begin
                        mosi    <= fifo_dout[SW-1];   // Next byte, no idle period
                        bit_cnt <= 3'd7;
                     end else begin
                        mosi  <= 1'b0;
                        state <= IO_GAP;
                     end
                  end
               end
            end
            IO_GAP: begin
               if (!half_done) begin
                  half_cnt <= half_cnt + 8'd1;
               end else begin
                  half_cnt <= 8'd0;
                  ss_n     <= 1'b1;   // Burst done
                  state    <= IO_IDLE;
               end
            end
            default: state <= IO_IDLE;
         endcase
      end
   end

   // Data shifter
   always_ff @(posedge clk) begin
      if (fifo_read)
         shreg <= {fifo_dout[SW-2:0], 1'b0};
      else if (fall && (bit_cnt != 3'd0))
         shreg <= {shreg[SW-2:0], 1'b0};
   end

   // Clock only toggles inside a frame
   a_sclk_in_frame: assert property (@(posedge clk) disable iff (!arst_n)
      sclk |-> !ss_n);

endmodule

`default_nettype wire

/* spi_master/spi_master.sv */
//######################################
// SPI master transmit top level. Core
// packets in, sclk/mosi/ss_n out. Sets
// FIFO depth and prog_full headroom
//######################################
`timescale 1ns/1ps
`default_nettype none

module spi_master import spi_pkg::*; #(
   parameter int DEPTH    = 16,   // Transmit FIFO entries
   parameter int PROG_GAP = 4     // prog_full headroom
) (
   input  logic          clk,
   input  logic          arst_n,
   input  logic          access_in,       // Core strobe
   input  logic [PW-1:0] packet_in,       // Core write packet
   output logic          wait_out,        // Core stall
   output logic          fifo_prog_full,  // TX FIFO nearly full
   output logic          sclk,
   output logic          mosi,
   output logic          ss_n
);

   logic          spi_en;
   logic [7:0]    clkdiv;
   logic [SW-1:0] fifo_dout;
   logic          fifo_empty;
   logic          fifo_read;

   emesh_if acc_if ();   // Decoded access

   //######################################
   // Core side
   //######################################
   emesh_decode dec0 (
      .access_in (access_in),
      .packet_in (packet_in),
      .wait_out  (wait_out),
      .acc       (acc_if.decoder)
   );

   spi_master_regs regs0 (
      .clk    (clk),
      .arst_n (arst_n),
      .acc    (acc_if.monitor),
      .spi_en (spi_en),
      .clkdiv (clkdiv)
   );

   spi_master_fifo #(
      .DEPTH    (DEPTH),
      .PROG_GAP (PROG_GAP)
   ) fifo0 (
      .clk            (clk),
      .arst_n         (arst_n),
      .spi_en         (spi_en),
      .acc            (acc_if.consumer),
      .fifo_read      (fifo_read),
      .fifo_empty     (fifo_empty),
      .fifo_dout      (fifo_dout),
      .fifo_prog_full (fifo_prog_full)
   );

   // Wire side
   spi_master_io io0 (
      .clk        (clk),
      .arst_n     (arst_n),
      .spi_en     (spi_en),
      .clkdiv     (clkdiv),
      .fifo_empty (fifo_empty),
      .fifo_dout  (fifo_dout),
      .fifo_read  (fifo_read),
      .sclk       (sclk),
      .mosi       (mosi),
      .ss_n       (ss_n)
   );

endmodule

`default_nettype wire

/* tb/tb_spi_master.sv */
//######################################
// Testbench for the SPI master. Drives
// core packets, rebuilds bytes off the
// wire and checks them against a model
//######################################
`timescale 1ns/1ps
`default_nettype none

module tb_spi_master import spi_pkg::*; ();

   localparam int MAX_DIV        = 7;                     // Slowest divider used
   localparam int TOTAL_BYTES    = 1 + 3 * 15 + 6 * 8 + 2 * 2;
   localparam int TIMEOUT_CYCLES = TOTAL_BYTES * 8 * 2 * (MAX_DIV + 1) + 2000;
   localparam logic [31:0] SEED  = 32'h9ca0;
   localparam logic [AW-1:0] BASE = 32'h8000_0000;        // Block base above the 6 bit offset

   typedef logic [SW-1:0] byte_q_t [$];

   logic          clk;
   logic          arst_n;
   logic          access_in;
   logic [PW-1:0] packet_in;
   logic          wait_out;
   logic          fifo_prog_full;
   logic          sclk;
   logic          mosi;
   logic          ss_n;

   byte_q_t       exp_q;              // Bytes still owed by the DUT
   byte_q_t       rx_q;               // Bytes rebuilt from the wire
   string         test_name = "init";
   logic [7:0]    cur_clkdiv = 8'd0;
   int            err_main = 0;
   int            err_cmp = 0;
   int            err_mon = 0;
   int            cycles = 0;

   // Wire monitor state
   logic          sclk_prev = 1'b0;
   logic          ss_prev = 1'b1;
   logic [SW-1:0] rx_shift = '0;
   int            rx_bits = 0;
   int            high_cnt = 0;
   int            periods = 0;        // sclk high times measured
   int            frames = 0;         // ss_n falling edges
   int            pf_cycles = 0;      // Cycles with prog_full up
   int            wait_run = 0;
   int            long_stalls = 0;    // wait_out runs past one DM_DOUBLE
   logic [SW-1:0] cmp_got;
   logic [SW-1:0] cmp_want;

   spi_master #(
      .DEPTH    (16),
      .PROG_GAP (4)
   ) dut0 (
      .clk            (clk),
      .arst_n         (arst_n),
      .access_in      (access_in),
      .packet_in      (packet_in),
      .wait_out       (wait_out),
      .fifo_prog_full (fifo_prog_full),
      .sclk           (sclk),
      .mosi           (mosi),
      .ss_n           (ss_n)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;   // 40 ns period
   end

   always @(posedge clk) cycles <= cycles + 1;

   //######################################
   // Reference model and compare tasks
   //######################################
   // Payload is srcaddr over data and the low byte goes first
   function automatic byte_q_t expected_bytes(datamode_e dm, logic [AW-1:0] data,
                                              logic [AW-1:0] src);
      byte_q_t     q;
      logic [63:0] payload;
      int          n;
      payload = {src, data};
      n = 1 << int'(dm);   // 1, 2, 4 or 8 bytes
      for (int i = 0; i < n; i++)
         q.push_back(payload[8*i +: 8]);
      return q;
   endfunction

   function automatic logic [PW-1:0] make_packet(logic wr, datamode_e dm, logic [AW-1:0] dst,
                                                 logic [AW-1:0] data, logic [AW-1:0] src);
      logic [PW-1:0] p;
      p          = '0;   // Ctrlmode left zero
      p[0]       = wr;
      p[2:1]     = dm;
      p[39:8]    = dst;
      p[71:40]   = data;
      p[103:72]  = src;
      return p;
   endfunction

   task automatic check_byte(input string what, input logic [SW-1:0] expected,
                             input logic [SW-1:0] actual, inout int errs);
      if (actual !== expected) begin
         $display("** Error [%s] %s: expected 0x%02h, actual 0x%02h",
                  test_name, what, expected, actual);
         errs++;
      end
   endtask

   task automatic check_period(input string what, input int expected, input int actual,
                               inout int errs);
      if (actual != expected) begin
         $display("** Error [%s] %s: expected %0d, actual %0d",
                  test_name, what, expected, actual);
         errs++;
      end
   endtask

   task automatic check_flag(input string what, input logic expected, input logic actual,
                             inout int errs);
      if (actual !== expected) begin
         $display("** Error [%s] %s: expected %b, actual %b",
                  test_name, what, expected, actual);
         errs++;
      end
   endtask

   //######################################
   // Core side driving
   //######################################
   // Hold the packet until wait_out is low at a rising edge
   task automatic drive_packet(input logic [PW-1:0] pkt);
      @(negedge clk);
      access_in = 1'b1;
      packet_in = pkt;
      while (wait_out)
         @(negedge clk);
      @(negedge clk);   // Taken at the edge just passed
      access_in = 1'b0;
   endtask

   task automatic write_reg(input logic [OW-1:0] offset, input logic [AW-1:0] data);
      drive_packet(make_packet(1'b1, DM_WORD, BASE | AW'(offset), data, '0));
      if (offset == SPI_CLKDIV)
         cur_clkdiv = data[7:0];   // Monitor's expected half-period
   endtask

   task automatic send_tx(input datamode_e dm, input logic [AW-1:0] data,
                          input logic [AW-1:0] src, input logic expect_out);
      byte_q_t q;
      if (expect_out) begin
         q = expected_bytes(dm, data, src);
         foreach (q[i])
            exp_q.push_back(q[i]);
      end
      drive_packet(make_packet(1'b1, dm, BASE | AW'(SPI_TX), data, src));
   endtask

   // Until every owed byte arrived and the frame closed
   task automatic wait_drain();
      int limit;
      int n;
      limit = exp_q.size() * SW * 2 * (int'(cur_clkdiv) + 1) + 200;   // Wire time of owed bytes
      n     = 0;
      while ((exp_q.size() != 0 || !ss_n) && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (n >= limit) begin
         $display("Wire in %s still busy with %0d bytes owed", test_name, exp_q.size());
         err_main++;
      end
   endtask

   task automatic finish_run(input logic timed_out);
      $display("Error counts: checks %0d, bytes %0d, wire %0d", err_main, err_cmp, err_mon);
      if (!timed_out && err_main + err_cmp + err_mon == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   endtask

   //######################################
   // Wire monitor sampled mid-cycle
   //######################################
   always @(negedge clk) begin
      if (fifo_prog_full)
         pf_cycles++;
      if (wait_out) begin
         wait_run++;
      end else begin
         if (wait_run > 8)
            long_stalls++;   // Longer than a plain 8 byte serialize
         wait_run = 0;
      end
      if (!ss_n && ss_prev)
         frames++;
      if (ss_n && !ss_prev && rx_bits != 0) begin
         $display("Frame in %s closed after %0d bits of a byte", test_name, rx_bits);
         err_mon++;
      end
      if (ss_n)
         rx_bits = 0;
      if (sclk && !sclk_prev && !ss_n) begin   // Rising sclk with mosi valid
         rx_shift = {rx_shift[SW-2:0], mosi};  // MSB first
         rx_bits++;
         if (rx_bits == SW) begin
            rx_q.push_back(rx_shift);
            rx_bits = 0;
         end
      end
      if (sclk) begin
         high_cnt++;
      end else if (sclk_prev) begin
         check_period("sclk high time", int'(cur_clkdiv) + 1, high_cnt, err_mon);
         periods++;
         high_cnt = 0;
      end
      sclk_prev = sclk;
      ss_prev   = ss_n;
   end

   // Compare each rebuilt byte with the head of the model queue
   always @(negedge clk) begin
      while (rx_q.size() > 0) begin
         cmp_got = rx_q.pop_front();
         if (exp_q.size() == 0) begin
            $display("Byte 0x%02h in %s arrived with none expected", cmp_got, test_name);
            err_cmp++;
         end else begin
            cmp_want = exp_q.pop_front();
            check_byte("mosi byte", cmp_want, cmp_got, err_cmp);
         end
      end
   end

   initial begin
      wait (cycles >= TIMEOUT_CYCLES);
      $display("Run stopped in %s after %0d cycles without finishing", test_name, cycles);
      finish_run(1'b1);
   end

   //######################################
   // Test sequence
   //######################################
   initial begin
      int pf0;
      int st0;
      int f0;
      int p0;
      void'($urandom(SEED));
      access_in = 1'b0;
      packet_in = '0;
      arst_n    = 1'b0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      test_name = "reset";
      check_flag("ss_n", 1'b1, ss_n, err_main);
      check_flag("sclk", 1'b0, sclk, err_main);
      check_flag("mosi", 1'b0, mosi, err_main);
      check_flag("wait_out", 1'b0, wait_out, err_main);

      test_name = "single byte";
      write_reg(SPI_CLKDIV, 32'd1);
      write_reg(SPI_CONFIG, 32'd1);
      send_tx(DM_BYTE, $urandom, $urandom, 1'b1);
      wait_drain();

      test_name = "datamodes";   // Every size in three rounds
      repeat (3) begin
         for (int m = 0; m < 4; m++)
            send_tx(datamode_e'(m[1:0]), $urandom, $urandom, 1'b1);
      end
      wait_drain();

      test_name = "backpressure";
      write_reg(SPI_CLKDIV, AW'(MAX_DIV));
      pf0 = pf_cycles;
      st0 = long_stalls;
      repeat (6)
         send_tx(DM_DOUBLE, $urandom, $urandom, 1'b1);
      check_flag("prog_full rose", 1'b1, pf_cycles > pf0, err_main);
      check_flag("core stalled", 1'b1, long_stalls > st0, err_main);
      wait_drain();

      test_name = "dropped";   // Nothing may reach the wire
      f0 = frames;
      write_reg(SPI_CONFIG, 32'd0);
      send_tx(DM_WORD, $urandom, $urandom, 1'b0);
      send_tx(DM_BYTE, $urandom, $urandom, 1'b0);
      write_reg(SPI_CONFIG, 32'd1);
      drive_packet(make_packet(1'b0, DM_WORD, BASE | AW'(SPI_TX), $urandom, $urandom));
      drive_packet(make_packet(1'b1, DM_HALF, BASE | 32'h0c, $urandom, $urandom));
      repeat (200) @(negedge clk);
      check_flag("no frame started", 1'b1, frames == f0, err_main);
      check_flag("ss_n idle", 1'b1, ss_n, err_main);

      test_name = "clkdiv";
      for (int k = 0; k < 2; k++) begin
         write_reg(SPI_CLKDIV, (k == 0) ? 32'd2 : 32'd5);
         p0 = periods;
         send_tx(DM_HALF, $urandom, $urandom, 1'b1);
         wait_drain();
         check_period("high times measured", 16, periods - p0, err_main);
      end

      test_name = "drain";
      repeat (20) @(negedge clk);
      check_flag("expected queue empty", 1'b1, exp_q.size() == 0, err_main);
      check_flag("prog_full", 1'b0, fifo_prog_full, err_main);
      check_flag("ss_n", 1'b1, ss_n, err_main);
      check_flag("sclk", 1'b0, sclk, err_main);
      check_flag("wait_out", 1'b0, wait_out, err_main);
      finish_run(1'b0);
   end

endmodule

`default_nettype wire

/* spi_master.f */
common/spi_pkg.sv
common/emesh_if.sv
logic/emesh_decode.sv
logic/par2ser.sv
logic/fifo_sync.sv
spi_master/spi_master_fifo.sv
spi_master/spi_master_regs.sv
spi_master/spi_master_io.sv
spi_master/spi_master.sv
tb/tb_spi_master.sv

/* Makefile */
# Verilator simulation of the SPI master transmit path

VERILATOR ?= verilator
TOP       ?= tb_spi_master
FILELIST  ?= spi_master.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^ALL TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
